//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_spi_ctl
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- spi_ctl_pkg.sv
/*
  shared constants and enums for the SPI housekeeping block
  frame is 8 address bits then 8 data bits, MSB first, SPI mode 0
  select polarity vector is fixed here, not writable over SPI
*/

package spi_ctl_pkg;

  //////////////////////////////////////////////////////////////////////
  // frame geometry

  // one full write or read frame
  localparam int frame_bits = 16;

  // address field, sent first
  localparam int addr_bits = 8;

  // data field follows the address
  localparam int data_bits = frame_bits - addr_bits;

  // bit counter must reach frame_bits without wrapping
  localparam int cnt_bits = $clog2(frame_bits + 1);

  // set/clear registers are one nibble wide
  localparam int nibble_bits = 4;

  //////////////////////////////////////////////////////////////////////
  // routing

  // downstream peripherals on the second select
  localparam int num_periph = 8;

  // bit n set -> peripheral n select is active high
  // lane 0 is the 4094 strobe, which latches on a high level
  localparam logic [num_periph-1:0] periph_ss_polarity = 8'b0000_0001;

  //////////////////////////////////////////////////////////////////////
  // register bank

  // led 0 lit after reset, a visible sign of life
  localparam logic [nibble_bits-1:0] led_reset_value = 4'b0001;

  // address field values; anything else is ignored on write
  // and reads back as zero
  typedef enum logic [addr_bits-1:0] {
    addr_led        = 8'd7,
    addr_route      = 8'd8,
    addr_oe_4094    = 8'd9,
    addr_soft_reset = 8'd11,
    addr_adc        = 8'd14
  } reg_addr_e;

  // frame phase tracked by the bank
  // overrun means more than frame_bits clocks, frame is dropped
  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data,
    st_overrun
  } bank_state_e;

endpackage

//--- spi_ctl_top.sv
/*
  housekeeping block top; spi_ss_n reaches the registers, spi_ss2_n the peripherals
  a write takes effect 3 cs cycles after spi_ss_n rises
*/
`timescale 1ns/100ps

module spi_ctl_top (
  input  logic                                cs,
  input  logic                                reset,
  input  logic                                spi_sck,
  input  logic                                spi_ss_n,
  input  logic                                spi_ss2_n,
  input  logic                                spi_mosi,
  input  logic [spi_ctl_pkg::num_periph-1:0]  periph_miso,
  output logic                                spi_miso,
  output logic [spi_ctl_pkg::nibble_bits-1:0] led,
  output logic [spi_ctl_pkg::nibble_bits-1:0] oe_4094,
  output logic [spi_ctl_pkg::nibble_bits-1:0] adc_ctl,
  output logic [spi_ctl_pkg::num_periph-1:0]  periph_ss,
  output logic [spi_ctl_pkg::num_periph-1:0]  periph_sck,
  output logic [spi_ctl_pkg::num_periph-1:0]  periph_mosi
);

  import spi_ctl_pkg::*;

  // synchronized pin events
  logic sck_rise;
  logic sck_fall;
  logic frame_active;
  logic frame_end;
  logic mosi_bit;

  // bank to router
  logic                 bank_sdo;
  logic [data_bits-1:0] reg_route;

  spi_pin_sync u_pin_sync (
    .cs           (cs),
    .reset        (reset),
    .spi_sck      (spi_sck),
    .spi_ss_n     (spi_ss_n),
    .spi_ss2_n    (spi_ss2_n),
    .spi_mosi     (spi_mosi),
    .sck_rise     (sck_rise),
    .sck_fall     (sck_fall),
    .frame_active (frame_active),
    .frame_end    (frame_end),
    .mosi_bit     (mosi_bit)
  );

  spi_reg_bank u_reg_bank (
    .cs           (cs),
    .reset        (reset),
    .sck_rise     (sck_rise),
    .sck_fall     (sck_fall),
    .frame_active (frame_active),
    .frame_end    (frame_end),
    .mosi_bit     (mosi_bit),
    .bank_sdo     (bank_sdo),
    .reg_led      (led),
    .reg_route    (reg_route),
    .reg_oe_4094  (oe_4094),
    .reg_adc      (adc_ctl)
  );

  // raw pins here, routing must not see the synchronizer delay
  spi_route u_route (
    .reg_route   (reg_route),
    .spi_ss2_n   (spi_ss2_n),
    .spi_sck     (spi_sck),
    .spi_mosi    (spi_mosi),
    .periph_miso (periph_miso),
    .bank_sdo    (bank_sdo),
    .periph_ss   (periph_ss),
    .periph_sck  (periph_sck),
    .periph_mosi (periph_mosi),
    .spi_miso    (spi_miso)
  );

endmodule

//--- spi_pin_sync.sv
/*
  SPI pins are asynchronous to cs; two flops each, pulses 2 cs cycles late
  host must hold each SPI clock half-period for at least 4 cs cycles
  sck edges are dropped unless ss_n is low and ss2_n is high
*/
`timescale 1ns/100ps

module spi_pin_sync (
  input  logic cs,
  input  logic reset,
  input  logic spi_sck,
  input  logic spi_ss_n,
  input  logic spi_ss2_n,
  input  logic spi_mosi,
  output logic sck_rise,
  output logic sck_fall,
  output logic frame_active,
  output logic frame_end,
  output logic mosi_bit
);

  // bit 1 is the settled copy
  logic [1:0] sck_sync;
  logic [1:0] ss_sync;
  logic [1:0] ss2_sync;
  logic [1:0] mosi_sync;

  // previous settled values, for edge detect
  logic sck_prev;
  logic ss_prev;

  // bank listens only when its own select is low
  // and no pass-through transfer is running
  logic edge_en;

  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      // selects idle high, clock idles low in mode 0
      sck_sync  <= 2'b00;
      ss_sync   <= 2'b11;
      ss2_sync  <= 2'b11;
      mosi_sync <= 2'b00;
      sck_prev  <= 1'b0;
      ss_prev   <= 1'b1;
    end
    else
    begin
      sck_sync  <= {sck_sync[0], spi_sck};
      ss_sync   <= {ss_sync[0], spi_ss_n};
      ss2_sync  <= {ss2_sync[0], spi_ss2_n};
      mosi_sync <= {mosi_sync[0], spi_mosi};
      sck_prev  <= sck_sync[1];
      ss_prev   <= ss_sync[1];
    end
  end

  assign edge_en = ~ss_sync[1] & ss2_sync[1];

  // single cycle strobes
  assign sck_rise = edge_en & sck_sync[1] & ~sck_prev;
  assign sck_fall = edge_en & ~sck_sync[1] & sck_prev;

  // frame ends on ss_n going back high
  assign frame_active = ~ss_sync[1];
  assign frame_end    = ss_sync[1] & ~ss_prev;

  assign mosi_bit = mosi_sync[1];

endmodule

//--- spi_reg_bank.sv
/*
  register bank behind the primary SPI select, all logic on cs
  a write commits on frame_end only if exactly frame_bits bits arrived
  readback covers led, route and oe_4094; adc and unknown addresses read 0
*/
`timescale 1ns/100ps

module spi_reg_bank (
  input  logic cs,
  input  logic reset,
  input  logic sck_rise,
  input  logic sck_fall,
  input  logic frame_active,
  input  logic frame_end,
  input  logic mosi_bit,
  output logic bank_sdo,
  output logic [spi_ctl_pkg::nibble_bits-1:0] reg_led,
  output logic [spi_ctl_pkg::data_bits-1:0]   reg_route,
  output logic [spi_ctl_pkg::nibble_bits-1:0] reg_oe_4094,
  output logic [spi_ctl_pkg::nibble_bits-1:0] reg_adc
);

  import spi_ctl_pkg::*;

  bank_state_e state;

  // rising clocks seen this frame, saturates at frame_bits
  logic [cnt_bits-1:0] bit_cnt;

  // incoming frame, address ends up in the top byte
  logic [frame_bits-1:0] frame_sr;

  // address as it stands once the 8th bit is in
  logic [addr_bits-1:0] addr_next;

  // readback path
  logic [data_bits-1:0] rd_value;
  logic [data_bits-1:0] rd_shift;
  logic                 sdo_bit;

  // fields of the finished frame
  logic [addr_bits-1:0]   frame_addr;
  logic [data_bits-1:0]   frame_data;
  logic [nibble_bits-1:0] set_bits;
  logic [nibble_bits-1:0] clr_bits;
  logic                   commit;

  // set/clear update of a nibble register
  // a bit both set and cleared toggles instead
  function automatic logic [nibble_bits-1:0] update_nibble(
    input logic [nibble_bits-1:0] old_val,
    input logic [nibble_bits-1:0] set_val,
    input logic [nibble_bits-1:0] clr_val
  );
    logic [nibble_bits-1:0] both;
    both = set_val & clr_val;
    if (both != '0)
      return old_val ^ both;
    else
      return (old_val | set_val) & ~clr_val;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // frame phase and bit count

  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      state   <= st_idle;
      bit_cnt <= '0;
      sdo_bit <= 1'b0;
    end
    else if (!frame_active)
    begin
      // between frames, ready for the next one
      state   <= st_idle;
      bit_cnt <= '0;
      sdo_bit <= 1'b0;
    end
    else
    begin
      if (state == st_idle)
        state <= st_addr;

      if (sck_rise)
      begin
        // one clock too many, frame is spoilt
        if (bit_cnt == cnt_bits'(frame_bits))
          state <= st_overrun;
        else
        begin
          bit_cnt <= bit_cnt + 1'b1;
          // 8th address bit arriving
          if (bit_cnt == cnt_bits'(addr_bits - 1))
            state <= st_data;
        end
      end

      // read data moves after the falling edge, host samples on the rise
      if (sck_fall && state == st_data)
        sdo_bit <= rd_shift[data_bits-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // shifters

  assign addr_next = {frame_sr[addr_bits-2:0], mosi_bit};

  always_ff @(posedge cs)
  begin
    if (sck_rise && state != st_overrun)
      frame_sr <= {frame_sr[frame_bits-2:0], mosi_bit};
  end

  // value to send back, picked as the address completes
  always_comb
  begin
    case (addr_next)
      addr_led:     rd_value = data_bits'(reg_led);
      addr_route:   rd_value = reg_route;
      addr_oe_4094: rd_value = data_bits'(reg_oe_4094);
      default:      rd_value = '0;
    endcase
  end

  // load at the address boundary, then MSB first with zero fill
  always_ff @(posedge cs)
  begin
    if (sck_rise && bit_cnt == cnt_bits'(addr_bits - 1))
      rd_shift <= rd_value;
    else if (sck_fall && state == st_data)
      rd_shift <= {rd_shift[data_bits-2:0], 1'b0};
  end

  // quiet whenever the bank is not selected
  assign bank_sdo = sdo_bit & frame_active;

  //////////////////////////////////////////////////////////////////////
  // write commit

  assign frame_addr = frame_sr[frame_bits-1 -: addr_bits];
  assign frame_data = frame_sr[data_bits-1:0];
  assign set_bits   = frame_data[nibble_bits-1:0];
  assign clr_bits   = frame_data[data_bits-1 -: nibble_bits];

  // short frames stop in st_data with a low count, long ones in overrun
  assign commit = frame_end && state == st_data
                  && bit_cnt == cnt_bits'(frame_bits);

  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      reg_led     <= led_reset_value;
      reg_route   <= '0;
      reg_oe_4094 <= '0;
      reg_adc     <= '0;
    end
    else if (commit)
    begin
      case (frame_addr)
        addr_led:     reg_led     <= update_nibble(reg_led, set_bits, clr_bits);
        addr_route:   reg_route   <= frame_data;
        addr_oe_4094: reg_oe_4094 <= update_nibble(reg_oe_4094, set_bits, clr_bits);
        addr_adc:     reg_adc     <= update_nibble(reg_adc, set_bits, clr_bits);
        addr_soft_reset:
        begin
          // 4094 outputs keep their enable across a soft reset
          reg_led   <= '0;
          reg_route <= '0;
          reg_adc   <= '0;
        end
        default:
        begin
        end
      endcase
    end
  end

endmodule

//--- spi_route.sv
/*
  pass-through from the host pins to one of num_periph peripherals
  purely combinational, no cs involvement; glitches follow the pins
  route values above num_periph select nothing
*/
`timescale 1ns/100ps

module spi_route (
  input  logic [spi_ctl_pkg::data_bits-1:0]  reg_route,
  input  logic                               spi_ss2_n,
  input  logic                               spi_sck,
  input  logic                               spi_mosi,
  input  logic [spi_ctl_pkg::num_periph-1:0] periph_miso,
  input  logic                               bank_sdo,
  output logic [spi_ctl_pkg::num_periph-1:0] periph_ss,
  output logic [spi_ctl_pkg::num_periph-1:0] periph_sck,
  output logic [spi_ctl_pkg::num_periph-1:0] periph_mosi,
  output logic                               spi_miso
);

  import spi_ctl_pkg::*;

  // one-hot lane, zero when route is 0 or out of range
  logic [num_periph-1:0] lane_sel;

  // lane select gated by the second host select
  logic [num_periph-1:0] ss_active;

  // route value v picks lane v-1
  always_comb
  begin
    lane_sel = '0;
    for (int i = 0; i < num_periph; i++)
      lane_sel[i] = (reg_route == data_bits'(i + 1));
  end

  assign ss_active = lane_sel & {num_periph{~spi_ss2_n}};

  // active-high lanes follow ss_active, active-low lanes the inverse
  assign periph_ss = ~(ss_active ^ periph_ss_polarity);

  // unselected lanes held low
  assign periph_sck  = lane_sel & {num_periph{spi_sck}};
  assign periph_mosi = lane_sel & {num_periph{spi_mosi}};

  // bank drives MISO unless a routed transfer is running
  assign spi_miso = spi_ss2_n ? bank_sdo : |(lane_sel & periph_miso);

endmodule

//--- tb_spi_ctl.sv
/*
  testbench for spi_ctl_top; the host is bit-banged at 8 cs cycles per SPI half-period
  expected registers come from a model of the set/clear/toggle and routing rules
  all pins change 1 ns after a rising cs edge
*/
`timescale 1ns/100ps

module tb_spi_ctl;

  import spi_ctl_pkg::*;

  logic       cs;
  logic       reset;
  logic       spi_sck;
  logic       spi_ss_n;
  logic       spi_ss2_n;
  logic       spi_mosi;
  logic [7:0] periph_miso;
  logic       spi_miso;
  logic [3:0] led;
  logic [3:0] oe_4094;
  logic [3:0] adc_ctl;
  logic [7:0] periph_ss;
  logic [7:0] periph_sck;
  logic [7:0] periph_mosi;

  // model of the register bank
  logic [3:0] m_led;
  logic [3:0] m_oe;
  logic [3:0] m_adc;
  logic [7:0] m_route;

  logic [31:0] lfsr;
  string       cur_test;
  int          err_start;
  int          tests = 0;
  int          checks = 0;
  int          errors = 0;

  // pending checks, drained by the compare process
  string       name_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];

  spi_ctl_top dut (.*);

  initial
  begin
    cs = 1'b0;
    forever
      #2 cs = ~cs;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model and random source

  // galois LFSR, one step per bit taken
  function automatic logic [31:0] next_rand(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++)
    begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return val;
  endfunction

  // low nibble sets, high nibble clears, overlap toggles
  function automatic logic [3:0] set_clear_ref(input logic [3:0] old, input logic [7:0] data);
    logic [3:0] set_m;
    logic [3:0] clr_m;
    logic [3:0] overlap;
    set_m   = data[3:0];
    clr_m   = data[7:4];
    overlap = set_m & clr_m;
    if (overlap != 4'b0000)
      return old ^ overlap;
    return (old | set_m) & ~clr_m;
  endfunction

  // adc and unknown addresses read as zero
  function automatic logic [7:0] model_read(input logic [7:0] addr);
    case (addr)
      addr_led:     return {4'h0, m_led};
      addr_route:   return m_route;
      addr_oe_4094: return {4'h0, m_oe};
      default:      return 8'h00;
    endcase
  endfunction

  task automatic model_write(input logic [7:0] addr, input logic [7:0] data);
    case (addr)
      addr_led:     m_led   = set_clear_ref(m_led, data);
      addr_route:   m_route = data;
      addr_oe_4094: m_oe    = set_clear_ref(m_oe, data);
      addr_adc:     m_adc   = set_clear_ref(m_adc, data);
      addr_soft_reset:
      begin
        m_led   = 4'h0;
        m_route = 8'h00;
        m_adc   = 4'h0;
      end
      default:
      begin
      end
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare process

  initial
  begin
    string       c_name;
    logic [31:0] c_exp;
    logic [31:0] c_act;
    forever
    begin
      @(posedge cs);
      while (name_q.size() > 0)
      begin
        c_name = name_q.pop_front();
        c_exp  = exp_q.pop_front();
        c_act  = act_q.pop_front();
        checks++;
        if (c_exp !== c_act)
        begin
          errors++;
          $display("mismatch %s: expected %0h, actual %0h", c_name, c_exp, c_act);
        end
      end
    end
  end

  task automatic queue_check(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    name_q.push_back(name);
    exp_q.push_back(exp_val);
    act_q.push_back(act_val);
  endtask

  task automatic check_regs();
    queue_check({cur_test, " led"}, 32'(m_led), 32'(led));
    queue_check({cur_test, " oe_4094"}, 32'(m_oe), 32'(oe_4094));
    queue_check({cur_test, " adc_ctl"}, 32'(m_adc), 32'(adc_ctl));
  endtask

  // router outputs against the lane rules, pins as currently driven
  task automatic route_check(input logic [7:0] lane);
    logic [7:0] on;
    logic [7:0] ss_exp;
    logic       miso_exp;
    on       = spi_ss2_n ? 8'h00 : lane;
    ss_exp   = ~periph_ss_polarity ^ on;
    miso_exp = spi_ss2_n ? 1'b0 : |(lane & periph_miso);
    queue_check({cur_test, " periph_ss"}, 32'(ss_exp), 32'(periph_ss));
    queue_check({cur_test, " periph_sck"}, 32'(spi_sck ? lane : 8'h00), 32'(periph_sck));
    queue_check({cur_test, " periph_mosi"}, 32'(spi_mosi ? lane : 8'h00), 32'(periph_mosi));
    queue_check({cur_test, " spi_miso"}, 32'(miso_exp), 32'(spi_miso));
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    err_start = errors;
  endtask

  // wait for the compare process to catch up
  task automatic end_test();
    int n;
    n = 0;
    while (name_q.size() > 0 && n < 20)
    begin
      @(posedge cs);
      n++;
    end
    #1;
    if (name_q.size() > 0)
    begin
      errors++;
      $display("compare process stalled in test %s", cur_test);
    end
    tests++;
    if (errors == err_start)
      $display("test %s: ok", cur_test);
    else
      $display("test %s: %0d errors", cur_test, errors - err_start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // SPI host

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge cs);
    #1;
  endtask

  // nbits taken from word, MSB first; rd gets bits seen on rises 9 to 16
  task automatic shift_frame(input int nbits, input logic [31:0] word, output logic [7:0] rd);
    rd = 8'h00;
    spi_ss_n = 1'b0;
    wait_cycles(8);
    for (int i = 0; i < nbits; i++)
    begin
      spi_mosi = word[nbits - 1 - i];
      wait_cycles(8);
      if (i >= addr_bits && i < frame_bits)
        rd = {rd[6:0], spi_miso};
      spi_sck = 1'b1;
      wait_cycles(8);
      spi_sck = 1'b0;
    end
    wait_cycles(8);
    spi_ss_n = 1'b1;
    spi_mosi = 1'b0;
    // write lands 3 cycles after ss_n rises
    wait_cycles(4);
  endtask

  // full frame, readback and registers checked against the model
  task automatic reg_frame(input logic [7:0] addr, input logic [7:0] data);
    logic [7:0] exp_rd;
    logic [7:0] rd;
    exp_rd = model_read(addr);
    shift_frame(frame_bits, {16'h0000, addr, data}, rd);
    model_write(addr, data);
    queue_check({cur_test, " readback"}, 32'(exp_rd), 32'(rd));
    check_regs();
  endtask

  // pass-through transfer on the second select with random pins
  task automatic route_frame(input int v);
    logic [7:0] lane;
    lane = (v >= 1 && v <= num_periph) ? 8'(1 << (v - 1)) : 8'h00;
    route_check(lane);
    spi_ss2_n = 1'b0;
    wait_cycles(8);
    for (int i = 0; i < 8; i++)
    begin
      spi_mosi    = 1'(next_rand(1));
      periph_miso = 8'(next_rand(8));
      wait_cycles(8);
      route_check(lane);
      spi_sck = 1'b1;
      wait_cycles(8);
      route_check(lane);
      spi_sck = 1'b0;
    end
    wait_cycles(8);
    spi_ss2_n = 1'b1;
    wait_cycles(2);
    route_check(lane);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [7:0] addr;
    logic [1:0] sel;
    logic [7:0] rd;
    lfsr        = 32'h6a08b391;
    reset       = 1'b1;
    spi_sck     = 1'b0;
    spi_ss_n    = 1'b1;
    spi_ss2_n   = 1'b1;
    spi_mosi    = 1'b0;
    periph_miso = 8'h00;
    m_led       = led_reset_value;
    m_oe        = 4'h0;
    m_adc       = 4'h0;
    m_route     = 8'h00;
    repeat (3) @(posedge cs);
    #1;
    reset = 1'b0;
    wait_cycles(2);

    begin_test("reset_values");
    check_regs();
    route_check(8'h00);
    end_test();

    // overlapping set and clear nibbles come up often with random data
    begin_test("random_writes");
    for (int i = 0; i < 40; i++)
    begin
      sel  = 2'(next_rand(2));
      addr = (sel == 2'd0) ? addr_led : (sel == 2'd1) ? addr_oe_4094 : addr_adc;
      reg_frame(addr, 8'(next_rand(8)));
    end
    end_test();

    begin_test("readback");
    reg_frame(addr_route, 8'(next_rand(8)));
    reg_frame(addr_led, 8'h00);
    reg_frame(addr_route, m_route);
    reg_frame(addr_oe_4094, 8'h00);
    reg_frame(8'h5a, 8'h00);
    end_test();

    begin_test("routing");
    for (int v = 0; v <= num_periph; v++)
    begin
      reg_frame(addr_route, 8'(v));
      route_frame(v);
    end
    end_test();

    begin_test("soft_reset");
    reg_frame(addr_led, 8'h0e);
    reg_frame(addr_oe_4094, 8'h0b);
    reg_frame(addr_adc, 8'h07);
    reg_frame(addr_route, 8'h05);
    reg_frame(addr_soft_reset, 8'h00);
    reg_frame(addr_route, 8'h00);
    end_test();

    begin_test("frame_length");
    reg_frame(addr_led, 8'h06);
    reg_frame(addr_adc, 8'h09);
    // data nibble 0 lines the short frame up with addr_led in the shifter
    reg_frame(addr_oe_4094, 8'h80);
    // short frame whose tail would complete a led clear of all bits
    shift_frame(12, {20'h0, 4'(addr_led), 8'hf0}, rd);
    check_regs();
    shift_frame(20, {12'h0, addr_adc, 8'h0f, 4'h5}, rd);
    check_regs();
    shift_frame(20, {12'h0, addr_route, 8'h77, 4'h0}, rd);
    reg_frame(addr_route, m_route);
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- tb_spi_ctl_assert.sv
/*
  concurrent checks bound into spi_ctl_top, sampled on cs
  router outputs are combinational, sampled on the same clock
*/
`timescale 1ns/100ps

module tb_spi_ctl_assert (
  input logic                                cs,
  input logic                                reset,
  input logic                                frame_end,
  input logic                                frame_active,
  input logic                                bank_sdo,
  input logic [spi_ctl_pkg::nibble_bits-1:0] reg_led,
  input logic [spi_ctl_pkg::data_bits-1:0]   reg_route,
  input logic [spi_ctl_pkg::nibble_bits-1:0] reg_oe_4094,
  input logic [spi_ctl_pkg::nibble_bits-1:0] reg_adc,
  input logic [spi_ctl_pkg::num_periph-1:0]  periph_ss
);

  import spi_ctl_pkg::*;

  // lanes away from their idle level
  logic [num_periph-1:0] ss_moved;

  assign ss_moved = periph_ss ^ ~periph_ss_polarity;

  // registers move only on the cycle after a frame ends
  assert property (@(posedge cs) disable iff (reset)
    !$past(frame_end) |-> $stable({reg_led, reg_route, reg_oe_4094, reg_adc}))
  else
    $error("register bank changed outside a frame commit");

  assert property (@(posedge cs) disable iff (reset) $countones(ss_moved) <= 1)
  else
    $error("more than one peripheral select active");

  // readback bit left over from the last frame is gone when the next one opens
  assert property (@(posedge cs) disable iff (reset) $rose(frame_active) |-> !bank_sdo)
  else
    $error("bank_sdo high at the start of a frame");

endmodule

bind spi_ctl_top tb_spi_ctl_assert u_assert (
  .cs           (cs),
  .reset        (reset),
  .frame_end    (frame_end),
  .frame_active (frame_active),
  .bank_sdo     (bank_sdo),
  .reg_led      (led),
  .reg_route    (reg_route),
  .reg_oe_4094  (oe_4094),
  .reg_adc      (adc_ctl),
  .periph_ss    (periph_ss)
);

//--- vlog.f
spi_ctl_pkg.sv
spi_pin_sync.sv
spi_reg_bank.sv
spi_route.sv
spi_ctl_top.sv
tb_spi_ctl_assert.sv
tb_spi_ctl.sv
